/* hw/axi_pkg.sv */
// AXI protocol field widths, burst type and read response encodings
package axi_pkg;

    // --------------------
    // Field widths
    // --------------------

    // Burst length field, beats minus one
    localparam int AXI_LEN_W   = 8;
    // Size field, log2 of bytes per beat
    localparam int AXI_SIZE_W  = 3;
    // Burst type and response fields
    localparam int AXI_BURST_W = 2;
    localparam int AXI_RESP_W  = 2;

    // --------------------
    // Encodings
    // --------------------

    // Burst type as carried on arburst
    typedef enum logic [AXI_BURST_W-1:0] {
        AXI_BURST_FIXED    = 2'b00,
        AXI_BURST_INCR     = 2'b01,
        AXI_BURST_WRAP     = 2'b10,
        AXI_BURST_RESERVED = 2'b11
    } axi_burst_e;

    // Read response as carried on rresp
    typedef enum logic [AXI_RESP_W-1:0] {
        AXI_RESP_OKAY   = 2'b00,
        AXI_RESP_EXOKAY = 2'b01,
        AXI_RESP_SLVERR = 2'b10,
        AXI_RESP_DECERR = 2'b11
    } axi_resp_e;

endpackage

/* hw/rd_sub_pkg.sv */
// Read subordinate configuration: bus widths, component latency and pipeline depth
package rd_sub_pkg;

    // --------------------
    // Bus widths
    // --------------------

    // Byte address towards the manager and the component
    localparam int ADDR_W   = 32;
    // Read data word
    localparam int DATA_W   = 32;
    // Bytes per data word and the matching offset bits
    localparam int BYTE_CNT = DATA_W / 8;
    localparam int BYTE_W   = $clog2(BYTE_CNT);
    // Transaction ID
    localparam int ID_W     = 4;

    // --------------------
    // Pipeline
    // --------------------

    // Cycles from an issued request to valid rdata and err
    // Constant for a given component
    localparam int C_LAT       = 1;

    // One skid stage per latency cycle plus one, so every beat in flight
    // has a slot when the manager stalls
    localparam int SKID_STAGES = C_LAT + 1;

    // Per-beat context through the pipes
    // ID, last flag and read response
    localparam int CTX_W = ID_W + 1 + axi_pkg::AXI_RESP_W;

endpackage

/* hw/burst_addr_gen.sv */
// Next-beat address calculation for FIXED, INCR and WRAP bursts
`timescale 1ns/1ps

module burst_addr_gen (
    input  logic [rd_sub_pkg::ADDR_W-1:0]    i_addr,
    input  logic [axi_pkg::AXI_SIZE_W-1:0]   i_size,
    input  axi_pkg::axi_burst_e              i_burst,
    input  logic [axi_pkg::AXI_LEN_W-1:0]    i_len,
    output logic [rd_sub_pkg::ADDR_W-1:0]    o_next_addr
);

    // Bytes per beat, 2 to the power of size
    logic [rd_sub_pkg::ADDR_W-1:0] beat_bytes;
    // Address rounded down to the beat size
    logic [rd_sub_pkg::ADDR_W-1:0] aligned_addr;
    logic [rd_sub_pkg::ADDR_W-1:0] incr_addr;
    // Offset bits inside one wrap block
    logic [rd_sub_pkg::ADDR_W-1:0] wrap_mask;
    logic [rd_sub_pkg::ADDR_W-1:0] wrap_addr;

    assign beat_bytes   = rd_sub_pkg::ADDR_W'(1) << i_size;
    assign aligned_addr = i_addr & ~(beat_bytes - 1'b1);
    assign incr_addr    = aligned_addr + beat_bytes;

    // Wrap block is (len+1) beats, a power of two for legal WRAP bursts
    assign wrap_mask = ((rd_sub_pkg::ADDR_W'(i_len) + 1'b1) << i_size) - 1'b1;
    // Upper bits stay with the block, lower bits roll over
    assign wrap_addr = (i_addr & ~wrap_mask) | (incr_addr & wrap_mask);

    // --------------------
    // Burst type select
    // --------------------
    always_comb begin
        case (i_burst)
            axi_pkg::AXI_BURST_INCR: begin
                o_next_addr = incr_addr;
            end
            axi_pkg::AXI_BURST_WRAP: begin
                o_next_addr = wrap_addr;
            end
            default: begin
                // FIXED, and reserved treated the same way
                o_next_addr = i_addr;
            end
        endcase
    end

endmodule

/* hw/ar_tracker.sv */
// AR acceptance, active burst context, beat counter and component request strobe
`timescale 1ns/1ps

module ar_tracker (
    input  logic                              clk,
    input  logic                              rst_n,
    // AR channel
    input  logic                              i_arvalid,
    output logic                              o_arready,
    input  logic [rd_sub_pkg::ADDR_W-1:0]     i_araddr,
    input  logic [axi_pkg::AXI_BURST_W-1:0]   i_arburst,
    input  logic [axi_pkg::AXI_SIZE_W-1:0]    i_arsize,
    input  logic [axi_pkg::AXI_LEN_W-1:0]     i_arlen,
    input  logic [rd_sub_pkg::ID_W-1:0]       i_arid,
    // Flow control from the response pipe and the component
    input  logic                              i_space,
    input  logic                              i_hld,
    // Component request
    output logic                              o_dv,
    output logic [rd_sub_pkg::ADDR_W-1:0]     o_addr,
    output logic [rd_sub_pkg::ID_W-1:0]       o_id,
    // Burst context to the address generator
    output logic [rd_sub_pkg::ADDR_W-1:0]     o_cur_addr,
    output logic [axi_pkg::AXI_SIZE_W-1:0]    o_cur_size,
    output axi_pkg::axi_burst_e               o_cur_burst,
    output logic [axi_pkg::AXI_LEN_W-1:0]     o_cur_len,
    input  logic [rd_sub_pkg::ADDR_W-1:0]     i_next_addr,
    // Issued beat towards the context pipe
    output logic                              o_issue,
    output logic                              o_issue_last
);

    logic                           out_of_rst;
    logic                           active;
    logic                           ar_accept;
    logic                           final_issue;
    // Beats left after the current one
    logic [axi_pkg::AXI_LEN_W-1:0]  beat_cnt;

    // --------------------
    // AR handshake
    // --------------------

    // Ready again on the last issue so the next burst follows with no gap
    assign o_arready = out_of_rst && (!active || final_issue);
    assign ar_accept = i_arvalid && o_arready;

    // Keeps arready low in the first cycle after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_of_rst <= 1'b0;
        end else begin
            out_of_rst <= 1'b1;
        end
    end

    // Active while requests remain to be issued
    // Data for the last beats is still in flight after it drops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
        end else if (ar_accept) begin
            active <= 1'b1;
        end else if (final_issue) begin
            active <= 1'b0;
        end
    end

    // --------------------
    // Component request
    // --------------------

    // Request only while the response pipe can absorb a full stall
    assign o_dv         = active && i_space;
    assign o_issue      = o_dv && !i_hld;
    assign o_issue_last = (beat_cnt == '0);
    assign final_issue  = o_issue && o_issue_last;

    // Beat counter, held at zero once the burst is done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (ar_accept) begin
            beat_cnt <= i_arlen;
        end else if (o_issue && (beat_cnt != '0)) begin
            beat_cnt <= beat_cnt - 1'b1;
        end
    end

    // Burst context, loaded on accept and stepped per issue
    always_ff @(posedge clk) begin
        if (ar_accept) begin
            o_cur_addr  <= i_araddr;
            o_cur_size  <= i_arsize;
            o_cur_burst <= axi_pkg::axi_burst_e'(i_arburst);
            o_cur_len   <= i_arlen;
            o_id        <= i_arid;
        end else if (o_issue) begin
            o_cur_addr  <= i_next_addr;
        end
    end

    // Word-aligned address to the component
    assign o_addr = {o_cur_addr[rd_sub_pkg::ADDR_W-1:rd_sub_pkg::BYTE_W],
                     rd_sub_pkg::BYTE_W'(0)};

endmodule

/* hw/req_ctx_pipe.sv */
// Shift register carrying beat valid, ID and last across the component latency
`timescale 1ns/1ps

module req_ctx_pipe (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_valid,
    input  logic [rd_sub_pkg::ID_W-1:0]  i_id,
    input  logic                         i_last,
    output logic                         o_valid,
    output logic [rd_sub_pkg::ID_W-1:0]  o_id,
    output logic                         o_last
);

    // One register per latency cycle, index 0 nearest the issue
    logic [rd_sub_pkg::C_LAT-1:0]  vld_q;
    logic [rd_sub_pkg::ID_W-1:0]   id_q [rd_sub_pkg::C_LAT];
    logic [rd_sub_pkg::C_LAT-1:0]  last_q;

    // --------------------
    // Valid chain
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= i_valid;
            for (int i = 1; i < rd_sub_pkg::C_LAT; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // Context follows the valid chain, several beats may be in flight
    always_ff @(posedge clk) begin
        id_q[0]   <= i_id;
        last_q[0] <= i_last;
        for (int i = 1; i < rd_sub_pkg::C_LAT; i++) begin
            id_q[i]   <= id_q[i-1];
            last_q[i] <= last_q[i-1];
        end
    end

    // Lines up with the component rdata and err
    assign o_valid = vld_q[rd_sub_pkg::C_LAT-1];
    assign o_id    = id_q[rd_sub_pkg::C_LAT-1];
    assign o_last  = last_q[rd_sub_pkg::C_LAT-1];

endmodule

/* hw/skid_stage.sv */
// Two-entry skid buffer stage with registered output and valid/ready on both sides
`timescale 1ns/1ps

module skid_stage #(
    parameter int PAYLOAD_W = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Upstream
    input  logic                  i_valid,
    input  logic [PAYLOAD_W-1:0]  i_data,
    output logic                  o_ready,
    // Downstream
    input  logic                  i_ready,
    output logic                  o_valid,
    output logic [PAYLOAD_W-1:0]  o_data
);

    logic                  out_vld_q;
    logic [PAYLOAD_W-1:0]  out_data_q;
    // Spare entry, filled only while the output is stalled
    logic                  skid_vld_q;
    logic [PAYLOAD_W-1:0]  skid_data_q;
    // Output register free or draining this cycle
    logic                  out_load;
    logic                  in_accept;

    assign o_ready   = !skid_vld_q;
    assign in_accept = i_valid && o_ready;
    assign out_load  = !out_vld_q || i_ready;

    // --------------------
    // Control
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld_q  <= 1'b0;
            skid_vld_q <= 1'b0;
        end else if (out_load) begin
            // Spare entry drains first to keep order
            out_vld_q  <= skid_vld_q || i_valid;
            skid_vld_q <= 1'b0;
        end else if (in_accept) begin
            skid_vld_q <= 1'b1;
        end
    end

    // Payload follows the same selection
    always_ff @(posedge clk) begin
        if (out_load) begin
            out_data_q <= skid_vld_q ? skid_data_q : i_data;
        end else if (in_accept) begin
            skid_data_q <= i_data;
        end
    end

    assign o_valid = out_vld_q;
    assign o_data  = out_data_q;

endmodule

/* hw/resp_pipe.sv */
// Read response mapping, skid stage chain to the R channel and pipeline space flag
`timescale 1ns/1ps

module resp_pipe (
    input  logic                           clk,
    input  logic                           rst_n,
    // Beat from the context pipe, aligned with component data
    input  logic                           i_valid,
    input  logic [rd_sub_pkg::ID_W-1:0]    i_id,
    input  logic                           i_last,
    input  logic                           i_err,
    input  logic [rd_sub_pkg::DATA_W-1:0]  i_rdata,
    // Room for every beat in flight
    output logic                           o_space,
    // R channel
    input  logic                           i_rready,
    output logic                           o_rvalid,
    output logic [rd_sub_pkg::DATA_W-1:0]  o_rdata,
    output logic [rd_sub_pkg::ID_W-1:0]    o_rid,
    output axi_pkg::axi_resp_e             o_rresp,
    output logic                           o_rlast
);

    // Index 0 is the pipe input, SKID_STAGES is the R channel
    logic [rd_sub_pkg::DATA_W+rd_sub_pkg::CTX_W-1:0] stg_data [rd_sub_pkg::SKID_STAGES+1];
    logic [rd_sub_pkg::SKID_STAGES:0]   stg_valid;
    logic [rd_sub_pkg::SKID_STAGES:0]   stg_ready;
    axi_pkg::axi_resp_e                 in_resp;
    logic [axi_pkg::AXI_RESP_W-1:0]     out_resp;

    // Error is per beat
    assign in_resp = i_err ? axi_pkg::AXI_RESP_SLVERR : axi_pkg::AXI_RESP_OKAY;

    // --------------------
    // Stage chain
    // --------------------
    assign stg_valid[0] = i_valid;
    assign stg_data[0]  = {i_rdata, i_id, i_last, in_resp};

    for (genvar s = 0; s < rd_sub_pkg::SKID_STAGES; s++) begin : g_stage
        skid_stage #(
            .PAYLOAD_W (rd_sub_pkg::DATA_W + rd_sub_pkg::CTX_W)
        ) skid_stage_inst (
            .clk     (clk),
            .rst_n   (rst_n),
            .i_valid (stg_valid[s]),
            .i_data  (stg_data[s]),
            .o_ready (stg_ready[s]),
            .i_ready (stg_ready[s+1]),
            .o_valid (stg_valid[s+1]),
            .o_data  (stg_data[s+1])
        );
    end

    // Output end is stalled by the manager
    assign stg_ready[rd_sub_pkg::SKID_STAGES] = i_rready;

    // All stage readies, not rready
    // The last stage fills first, so this drops before any beat can be lost
    assign o_space = &stg_ready[rd_sub_pkg::SKID_STAGES-1:0];

    // --------------------
    // R channel
    // --------------------
    assign o_rvalid = stg_valid[rd_sub_pkg::SKID_STAGES];
    assign {o_rdata, o_rid, o_rlast, out_resp} = stg_data[rd_sub_pkg::SKID_STAGES];
    assign o_rresp  = axi_pkg::axi_resp_e'(out_resp);

endmodule

/* hw/rd_sub_top.sv */
// AXI read subordinate top level with tracker, address generator and pipes
`timescale 1ns/1ps

module rd_sub_top (
    input  logic                              clk,
    input  logic                              rst_n,
    // AR channel
    input  logic                              i_arvalid,
    output logic                              o_arready,
    input  logic [rd_sub_pkg::ADDR_W-1:0]     i_araddr,
    input  logic [axi_pkg::AXI_BURST_W-1:0]   i_arburst,
    input  logic [axi_pkg::AXI_SIZE_W-1:0]    i_arsize,
    input  logic [axi_pkg::AXI_LEN_W-1:0]     i_arlen,
    input  logic [rd_sub_pkg::ID_W-1:0]       i_arid,
    // R channel
    output logic                              o_rvalid,
    input  logic                              i_rready,
    output logic [rd_sub_pkg::DATA_W-1:0]     o_rdata,
    output logic [rd_sub_pkg::ID_W-1:0]       o_rid,
    output axi_pkg::axi_resp_e                o_rresp,
    output logic                              o_rlast,
    // Component side
    output logic                              o_dv,
    output logic [rd_sub_pkg::ADDR_W-1:0]     o_addr,
    output logic [rd_sub_pkg::ID_W-1:0]       o_id,
    input  logic                              i_hld,
    input  logic                              i_err,
    input  logic [rd_sub_pkg::DATA_W-1:0]     i_rdata
);

    // Burst context loop
    logic [rd_sub_pkg::ADDR_W-1:0]     cur_addr;
    logic [axi_pkg::AXI_SIZE_W-1:0]    cur_size;
    axi_pkg::axi_burst_e               cur_burst;
    logic [axi_pkg::AXI_LEN_W-1:0]     cur_len;
    logic [rd_sub_pkg::ADDR_W-1:0]     next_addr;
    // Issue and its delayed context
    logic                              issue;
    logic                              issue_last;
    logic                              ctx_valid;
    logic [rd_sub_pkg::ID_W-1:0]       ctx_id;
    logic                              ctx_last;
    logic                              space;

    // --------------------
    // Request side
    // --------------------
    ar_tracker ar_tracker_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_arvalid    (i_arvalid),
        .o_arready    (o_arready),
        .i_araddr     (i_araddr),
        .i_arburst    (i_arburst),
        .i_arsize     (i_arsize),
        .i_arlen      (i_arlen),
        .i_arid       (i_arid),
        .i_space      (space),
        .i_hld        (i_hld),
        .o_dv         (o_dv),
        .o_addr       (o_addr),
        .o_id         (o_id),
        .o_cur_addr   (cur_addr),
        .o_cur_size   (cur_size),
        .o_cur_burst  (cur_burst),
        .o_cur_len    (cur_len),
        .i_next_addr  (next_addr),
        .o_issue      (issue),
        .o_issue_last (issue_last)
    );

    // Unaligned start address kept so narrow beats step correctly
    burst_addr_gen burst_addr_gen_inst (
        .i_addr      (cur_addr),
        .i_size      (cur_size),
        .i_burst     (cur_burst),
        .i_len       (cur_len),
        .o_next_addr (next_addr)
    );

    // --------------------
    // Response side
    // --------------------
    req_ctx_pipe req_ctx_pipe_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (issue),
        .i_id    (o_id),
        .i_last  (issue_last),
        .o_valid (ctx_valid),
        .o_id    (ctx_id),
        .o_last  (ctx_last)
    );

    resp_pipe resp_pipe_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_valid  (ctx_valid),
        .i_id     (ctx_id),
        .i_last   (ctx_last),
        .i_err    (i_err),
        .i_rdata  (i_rdata),
        .o_space  (space),
        .i_rready (i_rready),
        .o_rvalid (o_rvalid),
        .o_rdata  (o_rdata),
        .o_rid    (o_rid),
        .o_rresp  (o_rresp),
        .o_rlast  (o_rlast)
    );

endmodule

/* sim/rd_sub_assert.sv */
// Bound assertions for AR and R handshake stability and response pipeline no-drop
`timescale 1ns/1ps

module rd_sub_assert (
    input logic                          clk,
    input logic                          rst_n,
    // AR channel
    input logic                          i_arvalid,
    input logic                          i_arready,
    input logic [rd_sub_pkg::ADDR_W-1:0] i_araddr,
    input logic [rd_sub_pkg::ID_W-1:0]   i_arid,
    // R channel
    input logic                          i_rvalid,
    input logic                          i_rready,
    input logic [rd_sub_pkg::DATA_W-1:0] i_rdata,
    input logic [rd_sub_pkg::ID_W-1:0]   i_rid,
    input axi_pkg::axi_resp_e            i_rresp,
    input logic                          i_rlast,
    // Response pipe input
    input logic                          i_pipe_valid,
    input logic                          i_pipe_ready
);

    // --------------------
    // R channel
    // --------------------

    // Stalled beat stays on the bus unchanged
    a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata) && $stable(i_rid)
            && $stable(i_rresp) && $stable(i_rlast))
        else $error("R beat changed or dropped while stalled");

    // --------------------
    // AR channel
    // --------------------

    // Manager keeps the request until it is taken
    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr) && $stable(i_arid))
        else $error("AR request withdrawn or changed before acceptance");

    // --------------------
    // Pipeline
    // --------------------

    // Component data has no way to wait, first stage must take it
    a_no_drop: assert property (@(posedge clk) disable iff (!rst_n)
        i_pipe_valid |-> i_pipe_ready)
        else $error("Component beat arrived while the response pipe was full");

endmodule

bind rd_sub_top rd_sub_assert rd_sub_assert_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_arvalid    (i_arvalid),
    .i_arready    (o_arready),
    .i_araddr     (i_araddr),
    .i_arid       (i_arid),
    .i_rvalid     (o_rvalid),
    .i_rready     (i_rready),
    .i_rdata      (o_rdata),
    .i_rid        (o_rid),
    .i_rresp      (o_rresp),
    .i_rlast      (o_rlast),
    .i_pipe_valid (ctx_valid),
    .i_pipe_ready (resp_pipe_inst.stg_ready[0])
);

/* sim/rd_sub_tb.sv */
// Testbench with clock, reset, component model, burst table, R-channel checker and report
`timescale 1ns/1ps

module rd_sub_tb;

    localparam int N_ROWS     = 8;
    // Cycle limits for each kind of wait
    localparam int WAIT_LIMIT = 400;
    localparam int DONE_LIMIT = 4000;
    // Component data pattern and inclusive error window of word addresses
    localparam logic [31:0] DATA_XOR = 32'h5a5a_0000;
    localparam logic [31:0] ERR_LO   = 32'h0000_1104;
    localparam logic [31:0] ERR_HI   = 32'h0000_1108;

    // One burst per row
    // Chain lets the AR go out before earlier bursts return
    typedef struct {
        string                          name;
        logic [rd_sub_pkg::ID_W-1:0]    id;
        logic [rd_sub_pkg::ADDR_W-1:0]  addr;
        axi_pkg::axi_burst_e            burst;
        logic [axi_pkg::AXI_SIZE_W-1:0] size;
        logic [axi_pkg::AXI_LEN_W-1:0]  len;
        bit                             err_exp;
        bit                             chain;
    } row_t;

    logic                             clk;
    logic                             rst_n;
    logic                             i_arvalid;
    logic                             o_arready;
    logic [rd_sub_pkg::ADDR_W-1:0]    i_araddr;
    logic [axi_pkg::AXI_BURST_W-1:0]  i_arburst;
    logic [axi_pkg::AXI_SIZE_W-1:0]   i_arsize;
    logic [axi_pkg::AXI_LEN_W-1:0]    i_arlen;
    logic [rd_sub_pkg::ID_W-1:0]      i_arid;
    logic                             o_rvalid;
    logic                             i_rready;
    logic [rd_sub_pkg::DATA_W-1:0]    o_rdata;
    logic [rd_sub_pkg::ID_W-1:0]      o_rid;
    axi_pkg::axi_resp_e               o_rresp;
    logic                             o_rlast;
    logic                             o_dv;
    logic [rd_sub_pkg::ADDR_W-1:0]    o_addr;
    logic [rd_sub_pkg::ID_W-1:0]      o_id;
    logic                             i_hld;
    logic                             i_err;
    logic [rd_sub_pkg::DATA_W-1:0]    i_rdata;

    row_t        tbl [N_ROWS];
    // Component latency line with the newest request at index 0
    logic [31:0] cmp_data [rd_sub_pkg::C_LAT];
    logic        cmp_err  [rd_sub_pkg::C_LAT];
    logic [31:0] lcg_state = 32'ha4fb4f93;
    // Checker progress
    int          rows_done    = 0;
    int          chk_beat     = 0;
    int          iss_row      = 0;
    int          iss_beat     = 0;
    int          row_errs [N_ROWS];
    int          row_slverr   = 0;
    int          errors       = 0;
    int          tests_passed = 0;
    bit          timed_out    = 1'b0;

    rd_sub_top rd_sub_top_inst (.*);

    // --------------------
    // Clock
    // --------------------
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bit in_err_window(input logic [31:0] word);
        return (word >= ERR_LO) && (word <= ERR_HI);
    endfunction

    function automatic logic [31:0] word_of(input logic [31:0] addr);
        return (addr >> rd_sub_pkg::BYTE_W) << rd_sub_pkg::BYTE_W;
    endfunction

    // Byte address of a beat from the AXI burst rules
    function automatic logic [31:0] beat_addr(input int r, input int beat);
        logic [31:0] nbytes;
        logic [31:0] total;
        logic [31:0] aligned;
        logic [31:0] lower;
        logic [31:0] addr;
        nbytes  = 32'd1 << tbl[r].size;
        total   = nbytes * (32'(tbl[r].len) + 32'd1);
        aligned = (tbl[r].addr / nbytes) * nbytes;
        lower   = (tbl[r].addr / total) * total;
        if (beat == 0 || tbl[r].burst == axi_pkg::AXI_BURST_FIXED) begin
            addr = tbl[r].addr;
        end else begin
            addr = aligned + 32'(beat) * nbytes;
            // Wrap back to the bottom of the block
            if (tbl[r].burst == axi_pkg::AXI_BURST_WRAP && addr >= lower + total) begin
                addr = addr - total;
            end
        end
        return addr;
    endfunction

    // --------------------
    // Burst table
    // --------------------
    task automatic load_table();
        tbl[0] = '{"incr4", 4'h1, 32'h0000_0100, axi_pkg::AXI_BURST_INCR, 3'd2, 8'd3, 0, 0};
        // Starts mid-block and wraps to 0x200
        tbl[1] = '{"wrap4", 4'h2, 32'h0000_0208, axi_pkg::AXI_BURST_WRAP, 3'd2, 8'd3, 0, 0};
        tbl[2] = '{"fixed3", 4'h3, 32'h0000_0304, axi_pkg::AXI_BURST_FIXED, 3'd2, 8'd2, 0, 0};
        // Middle two beats inside the error window
        tbl[3] = '{"err_window", 4'h4, 32'h0000_1100, axi_pkg::AXI_BURST_INCR, 3'd2, 8'd3,
                   1, 0};
        tbl[4] = '{"rand_long", 4'h5, 32'h0000_0400, axi_pkg::AXI_BURST_INCR, 3'd2, 8'd15,
                   0, 0};
        // Rows 5 to 7 go out back to back
        tbl[5] = '{"b2b_incr", 4'h6, 32'h0000_0800, axi_pkg::AXI_BURST_INCR, 3'd2, 8'd7, 0, 1};
        tbl[6] = '{"b2b_wrap", 4'h7, 32'h0000_0910, axi_pkg::AXI_BURST_WRAP, 3'd2, 8'd7, 0, 1};
        // Halfword beats with the second one in the error window
        tbl[7] = '{"b2b_narrow", 4'h8, 32'h0000_1102, axi_pkg::AXI_BURST_INCR, 3'd1, 8'd1,
                   1, 1};
    endtask

    // --------------------
    // Flow control and component data
    // --------------------

    // Test 1 runs with constant rready and hld
    always @(negedge clk) begin
        if (rows_done > 0) begin
            lcg_state = lcg_step(lcg_state);
            i_rready  = (lcg_state[31:30] != 2'b00);
            lcg_state = lcg_step(lcg_state);
            i_hld     = (lcg_state[31:30] != 2'b00);
        end
        i_rdata = cmp_data[rd_sub_pkg::C_LAT-1];
        i_err   = cmp_err[rd_sub_pkg::C_LAT-1];
    end

    // --------------------
    // Checker
    // --------------------
    task automatic report_mismatch(input int r, input int beat, input string field,
                                   input logic [31:0] exp_val, input logic [31:0] act_val);
        $display("MISMATCH %s beat %0d %s expected %h actual %h", tbl[r].name,
                 beat, field, exp_val, act_val);
        errors++;
        row_errs[r]++;
    endtask

    task automatic finish_row();
        if ((row_slverr != 0) != tbl[rows_done].err_exp) begin
            $display("Test %s returned %0d SLVERR beats but error expected is %0b",
                     tbl[rows_done].name, row_slverr, tbl[rows_done].err_exp);
            errors++;
            row_errs[rows_done]++;
        end
        $display("Test %0d %s: %0d beats, %s", rows_done, tbl[rows_done].name, chk_beat + 1,
                 (row_errs[rows_done] == 0) ? "pass" : "FAIL");
        if (row_errs[rows_done] == 0) begin
            tests_passed++;
        end
        chk_beat   = 0;
        row_slverr = 0;
        rows_done++;
    endtask

    // Component request against the burst rules, in issue order
    task automatic check_issue();
        logic [31:0] exp_addr;
        if (iss_row >= N_ROWS) begin
            $display("Extra component request at address %h after every burst was issued",
                     o_addr);
            errors++;
        end else begin
            exp_addr = word_of(beat_addr(iss_row, iss_beat));
            if (o_addr !== exp_addr) begin
                report_mismatch(iss_row, iss_beat, "addr", exp_addr, o_addr);
            end
            if (o_id !== tbl[iss_row].id) begin
                report_mismatch(iss_row, iss_beat, "id", 32'(tbl[iss_row].id), 32'(o_id));
            end
            if (iss_beat == int'(tbl[iss_row].len)) begin
                iss_row++;
                iss_beat = 0;
            end else begin
                iss_beat++;
            end
        end
    endtask

    task automatic check_beat();
        logic [31:0]        word;
        logic [31:0]        exp_data;
        axi_pkg::axi_resp_e exp_resp;
        logic               exp_last;
        if (rows_done >= N_ROWS) begin
            $display("Extra R beat with rid %0h after every burst completed", o_rid);
            errors++;
        end else begin
            word     = word_of(beat_addr(rows_done, chk_beat));
            exp_data = word ^ DATA_XOR;
            exp_resp = in_err_window(word) ? axi_pkg::AXI_RESP_SLVERR : axi_pkg::AXI_RESP_OKAY;
            exp_last = (chk_beat == int'(tbl[rows_done].len));
            if (o_rdata !== exp_data) begin
                report_mismatch(rows_done, chk_beat, "rdata", exp_data, o_rdata);
            end
            if (o_rid !== tbl[rows_done].id) begin
                report_mismatch(rows_done, chk_beat, "rid", 32'(tbl[rows_done].id),
                                32'(o_rid));
            end
            if (o_rresp !== exp_resp) begin
                report_mismatch(rows_done, chk_beat, "rresp", 32'(exp_resp), 32'(o_rresp));
            end
            if (o_rlast !== exp_last) begin
                report_mismatch(rows_done, chk_beat, "rlast", 32'(exp_last), 32'(o_rlast));
            end
            if (o_rresp == axi_pkg::AXI_RESP_SLVERR) begin
                row_slverr++;
            end
            if (exp_last) begin
                finish_row();
            end else begin
                chk_beat++;
            end
        end
    endtask

    // Component request and R transfer sampled before the edge updates
    always @(posedge clk) begin
        if (rst_n) begin
            for (int i = rd_sub_pkg::C_LAT - 1; i > 0; i--) begin
                cmp_data[i] = cmp_data[i-1];
                cmp_err[i]  = cmp_err[i-1];
            end
            // Component answers only a request it takes
            if (o_dv && !i_hld) begin
                check_issue();
                cmp_data[0] = o_addr ^ DATA_XOR;
                cmp_err[0]  = in_err_window(o_addr);
            end else begin
                cmp_data[0] = '0;
                cmp_err[0]  = 1'b0;
            end
            if (o_rvalid && i_rready) begin
                check_beat();
            end
        end
    end

    // --------------------
    // AR driver
    // --------------------
    task automatic send_ar(input int r);
        int n;
        n = 0;
        @(negedge clk);
        i_arvalid = 1'b0;
        while (!(tbl[r].chain || rows_done == r) && n < DONE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!(tbl[r].chain || rows_done == r)) begin
            $display("Timeout: earlier bursts never finished before test %s", tbl[r].name);
            errors++;
            timed_out = 1'b1;
        end else begin
            i_arvalid = 1'b1;
            i_araddr  = tbl[r].addr;
            i_arburst = tbl[r].burst;
            i_arsize  = tbl[r].size;
            i_arlen   = tbl[r].len;
            i_arid    = tbl[r].id;
            n = 0;
            @(posedge clk);
            while (!o_arready && n < WAIT_LIMIT) begin
                @(posedge clk);
                n++;
            end
            if (!o_arready) begin
                $display("Timeout: AR request of test %s was never accepted", tbl[r].name);
                errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int n;
        load_table();
        for (int i = 0; i < rd_sub_pkg::C_LAT; i++) begin
            cmp_data[i] = '0;
            cmp_err[i]  = 1'b0;
        end
        rst_n     = 1'b0;
        i_arvalid = 1'b0;
        i_araddr  = '0;
        i_arburst = '0;
        i_arsize  = '0;
        i_arlen   = '0;
        i_arid    = '0;
        i_rready  = 1'b1;
        i_hld     = 1'b0;
        i_err     = 1'b0;
        i_rdata   = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int r = 0; r < N_ROWS && !timed_out; r++) begin
            send_ar(r);
        end
        @(negedge clk);
        i_arvalid = 1'b0;

        // Remaining R beats
        n = 0;
        while (rows_done < N_ROWS && !timed_out && n < DONE_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (rows_done < N_ROWS && !timed_out) begin
            $display("Timeout: only %0d of %0d bursts completed", rows_done, N_ROWS);
            errors++;
        end
        // Idle window to catch stray beats
        repeat (20) @(posedge clk);

        $display("%0d of %0d tests passed, %0d errors", tests_passed, N_ROWS, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* rd_sub_top.f */
hw/axi_pkg.sv
hw/rd_sub_pkg.sv
hw/burst_addr_gen.sv
hw/ar_tracker.sv
hw/req_ctx_pipe.sv
hw/skid_stage.sv
hw/resp_pipe.sv
hw/rd_sub_top.sv
sim/rd_sub_assert.sv
sim/rd_sub_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the read subordinate testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    -f rd_sub_top.f \
    --top-module rd_sub_tb \
    -Mdir obj_dir -o rd_sub_sim \
    && ./obj_dir/rd_sub_sim > "$LOG" 2>&1 ; cat "$LOG" 2> /dev/null

grep -q "Everything OK" "$LOG" 2> /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see $LOG"; exit 1; }

exit 0
